// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

    //////////////////////////////////////////////////
    // Widths and base types
    //////////////////////////////////////////////////
    localparam int XLEN      = 64;
    localparam int INST_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    //////////////////////////////////////////////////
    // Instruction field positions
    //////////////////////////////////////////////////
    localparam int OPC_LSB = 0;
    localparam int OPC_MSB = 6;
    localparam int RD_LSB  = 7;
    localparam int RD_MSB  = 11;
    localparam int F3_LSB  = 12;
    localparam int F3_MSB  = 14;
    localparam int RS1_LSB = 15;
    localparam int RS1_MSB = 19;
    localparam int RS2_LSB = 20;
    localparam int RS2_MSB = 24;
    localparam int F7_LSB  = 25;
    localparam int F7_MSB  = 31;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB and SRA.

endpackage

// ==== design/id_ctrl_pkg.sv ====
package id_ctrl_pkg;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_type_e;

    typedef enum logic [2:0] {
        CMP_NONE = 3'd0,
        CMP_EQ   = 3'd1,
        CMP_NE   = 3'd2,
        CMP_LT   = 3'd3,
        CMP_GE   = 3'd4,
        CMP_LTU  = 3'd5,
        CMP_GEU  = 3'd6
    } comp_type_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Same coding as funct3[1:0] of loads and stores.
    typedef enum logic [1:0] {
        MEM_BYTE   = 2'b00,
        MEM_HALF   = 2'b01,
        MEM_WORD   = 2'b10,
        MEM_DOUBLE = 2'b11
    } mem_size_e;

endpackage

// ==== design/id_control.sv ====
`timescale 1ns/100ps
module id_control
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic       inst_valid_i,
    input  inst_t      inst_i,
    output imm_type_e  imm_type_o,
    output comp_type_e comp_type_o,
    output logic       rs1_used_o,
    output logic       rs2_used_o,
    output logic       jalr_base_rs1_o,
    output logic       is_jump_o,
    output logic       is_branch_o,
    output logic       is_lui_o,
    output logic       rd_en_o,
    output alu_op_e    alu_op_o,
    output logic       alu_src_pc_o,
    output logic       alu_src_imm_o,
    output logic       mem_read_o,
    output logic       mem_write_o,
    output mem_size_e  mem_size_o,
    output logic       load_unsigned_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       rd_en;
    logic       mem_read;
    logic       mem_write;
    logic       is_jump;
    logic       is_branch;
    alu_op_e    arith_op;

    assign opcode = inst_i[OPC_MSB:OPC_LSB];
    assign funct3 = inst_i[F3_MSB:F3_LSB];
    assign funct7 = inst_i[F7_MSB:F7_LSB];
    assign alt    = |(funct7 & F7_ALT); // Bit 30 only, shamt[5] may sit in funct7.

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    //////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////
    always_comb begin
        imm_type_o      = IMM_NONE;
        comp_type_o     = CMP_NONE;
        rs1_used_o      = 1'b0;
        rs2_used_o      = 1'b0;
        jalr_base_rs1_o = 1'b0;
        is_jump         = 1'b0;
        is_branch       = 1'b0;
        is_lui_o        = 1'b0;
        rd_en           = 1'b0;
        alu_op_o        = ALU_ADD;
        alu_src_pc_o    = 1'b0;
        alu_src_imm_o   = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_size_o      = MEM_BYTE;
        load_unsigned_o = 1'b0;
        case (opcode)
            OPC_LUI: begin
                imm_type_o    = IMM_U;
                is_lui_o      = 1'b1;
                rd_en         = 1'b1;
                alu_src_imm_o = 1'b1;
            end
            OPC_AUIPC: begin
                imm_type_o    = IMM_U;
                rd_en         = 1'b1;
                alu_src_pc_o  = 1'b1;
                alu_src_imm_o = 1'b1;
            end
            OPC_JAL: begin
                imm_type_o = IMM_J;
                is_jump    = 1'b1;
                rd_en      = 1'b1;
            end
            OPC_JALR: begin
                imm_type_o      = IMM_I;
                rs1_used_o      = 1'b1;
                jalr_base_rs1_o = 1'b1;
                is_jump         = 1'b1;
                rd_en           = 1'b1;
            end
            OPC_BRANCH: begin
                imm_type_o = IMM_B;
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                is_branch  = 1'b1;
                case (funct3)
                    3'b000:  comp_type_o = CMP_EQ;
                    3'b001:  comp_type_o = CMP_NE;
                    3'b100:  comp_type_o = CMP_LT;
                    3'b101:  comp_type_o = CMP_GE;
                    3'b110:  comp_type_o = CMP_LTU;
                    3'b111:  comp_type_o = CMP_GEU;
                    default: comp_type_o = CMP_NONE; // Reserved, never taken.
                endcase
            end
            OPC_LOAD: begin
                imm_type_o      = IMM_I;
                rs1_used_o      = 1'b1;
                rd_en           = 1'b1;
                alu_src_imm_o   = 1'b1;
                mem_read        = 1'b1;
                mem_size_o      = mem_size_e'(funct3[1:0]);
                load_unsigned_o = funct3[2];
            end
            OPC_STORE: begin
                imm_type_o    = IMM_S;
                rs1_used_o    = 1'b1;
                rs2_used_o    = 1'b1;
                alu_src_imm_o = 1'b1;
                mem_write     = 1'b1;
                mem_size_o    = mem_size_e'(funct3[1:0]);
            end
            OPC_OP_IMM: begin
                imm_type_o    = IMM_I;
                rs1_used_o    = 1'b1;
                rd_en         = 1'b1;
                alu_src_imm_o = 1'b1;
                alu_op_o      = arith_op;
            end
            OPC_OP: begin
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                rd_en      = 1'b1;
                alu_op_o   = arith_op;
            end
            default: begin
                rd_en = 1'b0; // Unknown opcode, nothing enabled.
            end
        endcase
    end

    assign rd_en_o     = rd_en & inst_valid_i;
    assign mem_read_o  = mem_read & inst_valid_i;
    assign mem_write_o = mem_write & inst_valid_i;
    assign is_jump_o   = is_jump & inst_valid_i;
    assign is_branch_o = is_branch & inst_valid_i;

endmodule

// ==== design/id_immgen.sv ====
`timescale 1ns/100ps
module id_immgen
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  imm_type_e imm_type_i,
    input  inst_t     inst_i,
    output xlen_t     imm_o
);

    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (imm_type_i)
            IMM_I:   imm_o = {{(XLEN-12){sign}}, inst_i[31:20]};
            IMM_S:   imm_o = {{(XLEN-12){sign}}, inst_i[31:25], inst_i[11:7]};
            IMM_B:   imm_o = {{(XLEN-13){sign}}, sign, inst_i[7], inst_i[30:25],
                              inst_i[11:8], 1'b0};
            IMM_U:   imm_o = {{(XLEN-32){sign}}, inst_i[31:12], 12'b0};
            IMM_J:   imm_o = {{(XLEN-21){sign}}, sign, inst_i[19:12], inst_i[20],
                              inst_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== design/id_regfile.sv ====
`timescale 1ns/100ps
module id_regfile
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  xlen_t    wr_data_i,
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o
);

    xlen_t regs [1:NUM_REGS-1]; // x0 has no storage.

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_idx_i != '0) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

// ==== design/id_forward.sv ====
`timescale 1ns/100ps
module id_forward
    import rv_isa_pkg::*;
(
    input  logic     rs1_used_i,
    input  logic     rs2_used_i,
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    input  xlen_t    rf_rs1_data_i,
    input  xlen_t    rf_rs2_data_i,
    input  logic     id2ex_rd_en_i,
    input  reg_idx_t id2ex_rd_idx_i,
    input  xlen_t    id2ex_rd_data_i,
    input  logic     ex2mem_rd_en_i,
    input  reg_idx_t ex2mem_rd_idx_i,
    input  xlen_t    ex2mem_rd_data_i,
    input  logic     mem2wb_rd_en_i,
    input  reg_idx_t mem2wb_rd_idx_i,
    input  xlen_t    mem2wb_rd_data_i,
    output xlen_t    rs1_data_o,
    output xlen_t    rs2_data_o
);

    // Youngest matching stage wins.
    function automatic xlen_t pick_src(input logic used, input reg_idx_t idx,
                                       input xlen_t rf_data);
        if (!used) begin
            return '0;
        end else if (idx == '0) begin
            return rf_data; // x0 is never forwarded.
        end else if (id2ex_rd_en_i && id2ex_rd_idx_i == idx) begin
            return id2ex_rd_data_i;
        end else if (ex2mem_rd_en_i && ex2mem_rd_idx_i == idx) begin
            return ex2mem_rd_data_i;
        end else if (mem2wb_rd_en_i && mem2wb_rd_idx_i == idx) begin
            return mem2wb_rd_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs1_data_o = pick_src(rs1_used_i, rs1_idx_i, rf_rs1_data_i);
        rs2_data_o = pick_src(rs2_used_i, rs2_idx_i, rf_rs2_data_i);
    end

endmodule

// ==== design/id_branchjudge.sv ====
`timescale 1ns/100ps
module id_branchjudge
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  comp_type_e comp_type_i,
    input  xlen_t      rs1_data_i,
    input  xlen_t      rs2_data_i,
    output logic       cond_ok_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (rs1_data_i == rs2_data_i);
    assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign lt_u = (rs1_data_i < rs2_data_i);

    always_comb begin
        case (comp_type_i)
            CMP_EQ:  cond_ok_o = eq;
            CMP_NE:  cond_ok_o = !eq;
            CMP_LT:  cond_ok_o = lt_s;
            CMP_GE:  cond_ok_o = !lt_s;
            CMP_LTU: cond_ok_o = lt_u;
            CMP_GEU: cond_ok_o = !lt_u;
            default: cond_ok_o = 1'b0;
        endcase
    end

endmodule

// ==== design/id_top.sv ====
`timescale 1ns/100ps
module id_top
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  xlen_t     pc_i,
    input  logic      id2ex_rd_en_i,
    input  reg_idx_t  id2ex_rd_idx_i,
    input  xlen_t     id2ex_rd_data_i,
    input  logic      ex2mem_rd_en_i,
    input  reg_idx_t  ex2mem_rd_idx_i,
    input  xlen_t     ex2mem_rd_data_i,
    input  logic      mem2wb_rd_en_i,
    input  reg_idx_t  mem2wb_rd_idx_i,
    input  xlen_t     mem2wb_rd_data_i,
    output reg_idx_t  rs1_idx_o,
    output reg_idx_t  rs2_idx_o,
    output reg_idx_t  rd_idx_o,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    output xlen_t     imm_o,
    output xlen_t     rd_data_o,
    output xlen_t     pc_o,
    output xlen_t     jumpbranch_addr_o,
    output logic      rd_en_o,
    output alu_op_e   alu_op_o,
    output logic      alu_src_pc_o,
    output logic      alu_src_imm_o,
    output logic      mem_read_o,
    output logic      mem_write_o,
    output mem_size_e mem_size_o,
    output logic      load_unsigned_o,
    output logic      jumpbranch_en_o
);

    imm_type_e  imm_type;
    comp_type_e comp_type;
    logic       rs1_used;
    logic       rs2_used;
    logic       jalr_base_rs1;
    logic       is_jump;
    logic       is_branch;
    logic       is_lui;
    logic       cond_ok;
    xlen_t      imm;
    xlen_t      rf_rs1_data;
    xlen_t      rf_rs2_data;
    xlen_t      rs1_fwd;
    xlen_t      rs2_fwd;
    xlen_t      jb_base;

    //////////////////////////////////////////////////
    // Stage outputs
    //////////////////////////////////////////////////
    assign rs1_idx_o  = inst_i[RS1_MSB:RS1_LSB];
    assign rs2_idx_o  = inst_i[RS2_MSB:RS2_LSB];
    assign rd_idx_o   = inst_i[RD_MSB:RD_LSB];
    assign rs1_data_o = rs1_fwd;
    assign rs2_data_o = rs2_fwd;
    assign imm_o      = imm;
    assign pc_o       = pc_i;

    assign jb_base           = jalr_base_rs1 ? rs1_fwd : pc_i;
    assign jumpbranch_addr_o = jb_base + imm;
    assign rd_data_o         = is_lui ? imm : pc_i + XLEN'(4); // Link value.
    assign jumpbranch_en_o   = is_jump | (is_branch & cond_ok);

    id_control id_control_inst (
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .imm_type_o      (imm_type),
        .comp_type_o     (comp_type),
        .rs1_used_o      (rs1_used),
        .rs2_used_o      (rs2_used),
        .jalr_base_rs1_o (jalr_base_rs1),
        .is_jump_o       (is_jump),
        .is_branch_o     (is_branch),
        .is_lui_o        (is_lui),
        .rd_en_o         (rd_en_o),
        .alu_op_o        (alu_op_o),
        .alu_src_pc_o    (alu_src_pc_o),
        .alu_src_imm_o   (alu_src_imm_o),
        .mem_read_o      (mem_read_o),
        .mem_write_o     (mem_write_o),
        .mem_size_o      (mem_size_o),
        .load_unsigned_o (load_unsigned_o)
    );

    id_immgen id_immgen_inst (
        .imm_type_i (imm_type),
        .inst_i     (inst_i),
        .imm_o      (imm)
    );

    id_regfile id_regfile_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (mem2wb_rd_en_i),
        .wr_idx_i   (mem2wb_rd_idx_i),
        .wr_data_i  (mem2wb_rd_data_i),
        .rs1_idx_i  (rs1_idx_o),
        .rs2_idx_i  (rs2_idx_o),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data)
    );

    id_forward id_forward_inst (
        .rs1_used_i       (rs1_used),
        .rs2_used_i       (rs2_used),
        .rs1_idx_i        (rs1_idx_o),
        .rs2_idx_i        (rs2_idx_o),
        .rf_rs1_data_i    (rf_rs1_data),
        .rf_rs2_data_i    (rf_rs2_data),
        .id2ex_rd_en_i    (id2ex_rd_en_i),
        .id2ex_rd_idx_i   (id2ex_rd_idx_i),
        .id2ex_rd_data_i  (id2ex_rd_data_i),
        .ex2mem_rd_en_i   (ex2mem_rd_en_i),
        .ex2mem_rd_idx_i  (ex2mem_rd_idx_i),
        .ex2mem_rd_data_i (ex2mem_rd_data_i),
        .mem2wb_rd_en_i   (mem2wb_rd_en_i),
        .mem2wb_rd_idx_i  (mem2wb_rd_idx_i),
        .mem2wb_rd_data_i (mem2wb_rd_data_i),
        .rs1_data_o       (rs1_fwd),
        .rs2_data_o       (rs2_fwd)
    );

    id_branchjudge id_branchjudge_inst (
        .comp_type_i (comp_type),
        .rs1_data_i  (rs1_fwd),
        .rs2_data_i  (rs2_fwd),
        .cond_ok_o   (cond_ok)
    );

endmodule

// ==== dv/id_top_tb.sv ====
`timescale 1ns/100ps
module id_top_tb
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
;

    localparam string STIM_FILE = "dv/id_top_stim.txt";

    logic      clk;
    logic      rst_n_i;
    logic      inst_valid_i;
    inst_t     inst_i;
    xlen_t     pc_i;
    logic      id2ex_rd_en_i, ex2mem_rd_en_i, mem2wb_rd_en_i;
    reg_idx_t  id2ex_rd_idx_i, ex2mem_rd_idx_i, mem2wb_rd_idx_i;
    xlen_t     id2ex_rd_data_i, ex2mem_rd_data_i, mem2wb_rd_data_i;
    reg_idx_t  rs1_idx_o, rs2_idx_o, rd_idx_o;
    xlen_t     rs1_data_o, rs2_data_o, imm_o, rd_data_o, pc_o, jumpbranch_addr_o;
    logic      rd_en_o, alu_src_pc_o, alu_src_imm_o, mem_read_o, mem_write_o;
    logic      load_unsigned_o, jumpbranch_en_o;
    alu_op_e   alu_op_o;
    mem_size_e mem_size_o;

    int cycles = 0;
    int cycle_limit = 25;

    id_top id_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit, sized once the vectors are counted.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("ERROR: %s expected 0x%h got 0x%h", name, exp, act);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) report_mismatch(name, exp, act);
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_alu_op(input string name, input alu_op_e exp, input alu_op_e act);
        if (act !== exp) report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_mem_size(input string name, input mem_size_e exp,
                                  input mem_size_e act);
        if (act !== exp) report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) report_mismatch(name, 64'(exp), 64'(act));
    endtask

    //////////////////////////////////////////////////
    // Vector file
    //////////////////////////////////////////////////
    function automatic int open_stim();
        int fd;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", STIM_FILE);
            $display("Testbench failed");
            $fatal(1);
        end
        return fd;
    endfunction

    function automatic int count_vectors();
        int fd;
        int n;
        string tag;
        string rest;
        fd = open_stim();
        n = 0;
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "W" || tag == "D") n++;
            void'($fgets(rest, fd));
        end
        $fclose(fd);
        return n;
    endfunction

    task automatic bad_line(input string tag);
        $display("Vector file has a malformed %s line", tag);
        $display("Testbench failed");
        $fatal(1);
    endtask

    initial begin
        int fd;
        string tag;
        string rest;
        logic [63:0] w_idx, w_data;
        logic [63:0] v, ins, pc, ie, ii, id, ee, ei, ed, me, mi, md;
        logic [63:0] x_rd_en, x_alu, x_spc, x_simm, x_mrd, x_mwr, x_msz, x_lu;
        logic [63:0] x_imm, x_rs1, x_rs2, x_rdd, x_jbe, x_jba;
        inst_t inst;

        rst_n_i          = 1'b0;
        inst_valid_i     = 1'b0;
        inst_i           = '0;
        pc_i             = '0;
        id2ex_rd_en_i    = 1'b0;
        id2ex_rd_idx_i   = '0;
        id2ex_rd_data_i  = '0;
        ex2mem_rd_en_i   = 1'b0;
        ex2mem_rd_idx_i  = '0;
        ex2mem_rd_data_i = '0;
        mem2wb_rd_en_i   = 1'b0;
        mem2wb_rd_idx_i  = '0;
        mem2wb_rd_data_i = '0;

        cycle_limit = count_vectors() + 5 + 20;

        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;

        fd = open_stim();
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "W") begin
                if ($fscanf(fd, "%h %h", w_idx, w_data) != 2) bad_line(tag);
                @(posedge clk);
                inst_valid_i     <= 1'b0;
                id2ex_rd_en_i    <= 1'b0;
                ex2mem_rd_en_i   <= 1'b0;
                mem2wb_rd_en_i   <= 1'b1;
                mem2wb_rd_idx_i  <= reg_idx_t'(w_idx);
                mem2wb_rd_data_i <= w_data;
            end else if (tag == "D") begin
                if ($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            v, ins, pc, ie, ii, id, ee, ei, ed, me, mi, md) != 12)
                    bad_line(tag);
                if ($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            x_rd_en, x_alu, x_spc, x_simm, x_mrd, x_mwr, x_msz, x_lu,
                            x_imm, x_rs1, x_rs2, x_rdd, x_jbe, x_jba) != 14)
                    bad_line(tag);
                inst = inst_t'(ins);
                @(posedge clk);
                inst_valid_i     <= v[0];
                inst_i           <= inst;
                pc_i             <= pc;
                id2ex_rd_en_i    <= ie[0];
                id2ex_rd_idx_i   <= reg_idx_t'(ii);
                id2ex_rd_data_i  <= id;
                ex2mem_rd_en_i   <= ee[0];
                ex2mem_rd_idx_i  <= reg_idx_t'(ei);
                ex2mem_rd_data_i <= ed;
                mem2wb_rd_en_i   <= me[0];
                mem2wb_rd_idx_i  <= reg_idx_t'(mi);
                mem2wb_rd_data_i <= md;
                @(negedge clk);
                check_idx("rs1_idx_o", inst[19:15], rs1_idx_o);
                check_idx("rs2_idx_o", inst[24:20], rs2_idx_o);
                check_idx("rd_idx_o", inst[11:7], rd_idx_o);
                check_word("pc_o", pc, pc_o);
                check_word("imm_o", x_imm, imm_o);
                check_word("rs1_data_o", x_rs1, rs1_data_o);
                check_word("rs2_data_o", x_rs2, rs2_data_o);
                check_word("rd_data_o", x_rdd, rd_data_o);
                check_word("jumpbranch_addr_o", x_jba, jumpbranch_addr_o);
                check_bit("rd_en_o", x_rd_en[0], rd_en_o);
                check_alu_op("alu_op_o", alu_op_e'(x_alu[3:0]), alu_op_o);
                check_bit("alu_src_pc_o", x_spc[0], alu_src_pc_o);
                check_bit("alu_src_imm_o", x_simm[0], alu_src_imm_o);
                check_bit("mem_read_o", x_mrd[0], mem_read_o);
                check_bit("mem_write_o", x_mwr[0], mem_write_o);
                check_mem_size("mem_size_o", mem_size_e'(x_msz[1:0]), mem_size_o);
                check_bit("load_unsigned_o", x_lu[0], load_unsigned_o);
                check_bit("jumpbranch_en_o", x_jbe[0], jumpbranch_en_o);
            end else begin
                void'($fgets(rest, fd)); // Comment line.
            end
        end
        $fclose(fd);

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== dv/id_top_stim.txt ====
# W idx data | D valid inst pc id2ex(en idx data) ex2mem(en idx data) mem2wb(en idx data)
# then rd_en alu_op src_pc src_imm mem_rd mem_wr size unsigned imm rs1 rs2 rd_data jb_en jb_addr
D 1 002082b3 100 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 104 0 100
W 1 1000
W 2 ffffffffffffffff
W 3 1
W 0 dead
D 1 002082b3 100 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 1000 ffffffffffffffff 104 0 100
D 1 40300333 100 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 1 104 0 100
D 1 004082b3 100 1 1 aaaa 1 1 bbbb 1 4 cccc 1 0 0 0 0 0 0 0 0 aaaa cccc 104 0 100
D 1 004002b3 100 1 0 1111 0 4 2222 0 0 0 1 0 0 0 0 0 0 0 0 0 cccc 104 0 100
D 1 800003b7 100 0 0 0 0 0 0 0 0 0 1 0 0 1 0 0 0 0 ffffffff80000000 0 0 ffffffff80000000 0 ffffffff80000100
D 1 12345397 200 0 0 0 0 0 0 0 0 0 1 0 1 1 0 0 0 0 12345000 0 0 204 0 12345200
D 1 ff9ff0ef 1000 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 fffffffffffffff8 0 0 1004 1 ff8
D 1 010080e7 2000 1 1 3000 0 0 0 0 0 0 1 0 0 0 0 0 0 0 10 3000 0 2004 1 3010
D 1 00208463 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 1000 ffffffffffffffff 104 0 108
D 1 fe3188e3 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 fffffffffffffff0 1 1 104 1 f0
D 1 00209463 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 1000 ffffffffffffffff 104 1 108
D 1 fe3198e3 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 fffffffffffffff0 1 1 104 0 f0
D 1 00314463 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 ffffffffffffffff 1 104 1 108
D 1 0021c463 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 1 ffffffffffffffff 104 0 108
D 1 fe21d8e3 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 fffffffffffffff0 1 ffffffffffffffff 104 1 f0
D 1 00315463 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 ffffffffffffffff 1 104 0 108
D 1 0021e463 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 1 ffffffffffffffff 104 1 108
D 1 00316463 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 ffffffffffffffff 1 104 0 108
D 1 fe3178e3 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 fffffffffffffff0 ffffffffffffffff 1 104 1 f0
D 1 0021f463 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8 1 ffffffffffffffff 104 0 108
D 1 40415413 100 0 0 0 0 0 0 0 0 0 1 7 0 1 0 0 0 0 404 ffffffffffffffff 0 104 0 504
D 1 0020f4b3 100 0 0 0 0 0 0 0 0 0 1 9 0 0 0 0 0 0 0 1000 ffffffffffffffff 104 0 100
D 1 ffc0d503 100 0 0 0 0 0 0 0 0 0 1 0 0 1 1 0 1 1 fffffffffffffffc 1000 0 104 0 fc
D 1 0041b423 100 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 3 0 8 1 cccc 104 0 108
D 0 ff9ff0ef 1000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 fffffffffffffff8 0 0 1004 0 ff8
D 0 ffc0d503 100 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 1 fffffffffffffffc 1000 0 104 0 fc

// ==== src.f ====
design/rv_isa_pkg.sv
design/id_ctrl_pkg.sv
design/id_control.sv
design/id_immgen.sv
design/id_regfile.sv
design/id_forward.sv
design/id_branchjudge.sv
design/id_top.sv
dv/id_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing -Wno-fatal
TB_TOP    := id_top_tb
RTL_TOP   := id_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
